//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= sim.f
TOP       ?= tbAluTop
RTL_TOP   ?= aluTop
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- sim.f
src/aluPkg.sv
src/adder64.sv
src/aluDecode.sv
src/alu.sv
src/aluRegs.sv
src/aluTop.sv
tb/tbAluTop.sv

//--- src/adder64.sv
// 64-bit adder with flags
`timescale 1ns/1ps
`default_nettype none

module adder64 import aluPkg::*; (
    input  logic [DATA_WIDTH-1:0] x,
    input  logic [DATA_WIDTH-1:0] y,        // already inverted for subtraction.
    input  logic                  sub,
    output logic [DATA_WIDTH-1:0] sum,
    output logic                  carry,
    output logic                  overflow,
    output logic                  sign,
    output logic                  zeroFlag
);

    logic [DATA_WIDTH:0] wide;

    assign wide = {1'b0, x} + {1'b0, y} + {{DATA_WIDTH{1'b0}}, sub};
    assign sum  = wide[DATA_WIDTH-1:0];

    // for subtraction carry is set when no borrow occurred.
    assign carry    = wide[DATA_WIDTH];
    assign overflow = (x[DATA_WIDTH-1] == y[DATA_WIDTH-1]) &&
                      (sum[DATA_WIDTH-1] != x[DATA_WIDTH-1]);
    assign sign     = sum[DATA_WIDTH-1];
    assign zeroFlag = (sum == '0);

endmodule

`default_nettype wire

//--- src/alu.sv
// 64-bit integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu import aluPkg::*; (
    input  logic [DATA_WIDTH-1:0] operandA,
    input  logic [DATA_WIDTH-1:0] operandB,
    input  aluOpE                 aluOp,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  zero
);

    logic      subtract;
    logic      signedCmp;
    logic      arithShift;
    logic      shiftRight;
    logic      wordMode;
    resultSelE resultSel;

    logic [DATA_WIDTH-1:0] adderY;
    logic [DATA_WIDTH-1:0] sum;
    logic [DATA_WIDTH-1:0] adderRes;
    logic                  carry;
    logic                  overflow;
    logic                  sign;
    logic                  lessThan;

    logic [5:0]            shamt;
    logic [4:0]            shamtW;
    logic [31:0]           sllW;
    logic [31:0]           srlW;
    logic [31:0]           sraW;
    logic [31:0]           shiftWord;
    logic [DATA_WIDTH-1:0] sllD;
    logic [DATA_WIDTH-1:0] srlD;
    logic [DATA_WIDTH-1:0] sraD;
    logic [DATA_WIDTH-1:0] shiftDouble;
    logic [DATA_WIDTH-1:0] shiftOut;

    aluDecode decode (
        .aluOp     (aluOp),
        .subtract  (subtract),
        .signedCmp (signedCmp),
        .arithShift(arithShift),
        .shiftRight(shiftRight),
        .wordMode  (wordMode),
        .resultSel (resultSel)
    );

    assign adderY = operandB ^ {DATA_WIDTH{subtract}};

    adder64 adder (
        .x       (operandA),
        .y       (adderY),
        .sub     (subtract),
        .sum     (sum),
        .carry   (carry),
        .overflow(overflow),
        .sign    (sign),
        .zeroFlag(zero)
    );

    assign adderRes = wordMode ? {{32{sum[31]}}, sum[31:0]} : sum;
    assign lessThan = signedCmp ? (overflow ^ sign) : ~carry;

    assign shamt  = operandB[5:0];
    assign shamtW = operandB[4:0];  // word forms only see the low 32 bits.

    assign sllW = operandA[31:0] << shamtW;
    assign srlW = operandA[31:0] >> shamtW;
    assign sraW = $signed(operandA[31:0]) >>> shamtW;
    assign sllD = operandA << shamt;
    assign srlD = operandA >> shamt;
    assign sraD = $signed(operandA) >>> shamt;

    assign shiftWord   = !shiftRight ? sllW : (arithShift ? sraW : srlW);
    assign shiftDouble = !shiftRight ? sllD : (arithShift ? sraD : srlD);
    assign shiftOut    = wordMode ? {{32{shiftWord[31]}}, shiftWord} : shiftDouble;

    always_comb begin
        case (resultSel)
            SEL_AND:   result = operandA & operandB;
            SEL_OR:    result = operandA | operandB;
            SEL_XOR:   result = operandA ^ operandB;
            SEL_SHIFT: result = shiftOut;
            SEL_PASSB: result = operandB;
            SEL_CMP:   result = {{(DATA_WIDTH-1){1'b0}}, lessThan};
            default:   result = adderRes;
        endcase
    end

endmodule

`default_nettype wire

//--- src/aluDecode.sv
// ALU opcode decoder
`timescale 1ns/1ps
`default_nettype none

module aluDecode import aluPkg::*; (
    input  aluOpE     aluOp,
    output logic      subtract,
    output logic      signedCmp,
    output logic      arithShift,
    output logic      shiftRight,
    output logic      wordMode,
    output resultSelE resultSel
);

    always_comb begin
        subtract   = 1'b0;
        signedCmp  = 1'b0;
        arithShift = 1'b0;
        shiftRight = 1'b0;
        wordMode   = 1'b0;
        resultSel  = SEL_ADDER;
        case (aluOp)
            OP_ADDW: wordMode = 1'b1;
            OP_SUB: subtract = 1'b1;
            OP_SUBW: begin
                subtract = 1'b1;
                wordMode = 1'b1;
            end
            OP_SLL: resultSel = SEL_SHIFT;
            OP_SLLW: begin
                resultSel = SEL_SHIFT;
                wordMode  = 1'b1;
            end
            OP_SRL, OP_SRLW, OP_SRA, OP_SRAW: begin
                resultSel  = SEL_SHIFT;
                shiftRight = 1'b1;
                arithShift = (aluOp == OP_SRA) || (aluOp == OP_SRAW);
                wordMode   = aluOp[4];
            end
            OP_SLT, OP_SLTU: begin
                resultSel = SEL_CMP;
                subtract  = 1'b1;
                signedCmp = (aluOp == OP_SLT);
            end
            OP_XOR: resultSel = SEL_XOR;
            OP_OR: resultSel = SEL_OR;
            OP_AND: resultSel = SEL_AND;
            OP_PASSB: resultSel = SEL_PASSB;
            default: ;  // add, and any undefined code.
        endcase
    end

endmodule

`default_nettype wire

//--- src/aluPkg.sv
// ALU coprocessor shared definitions
`default_nettype none

package aluPkg;

    localparam int DATA_WIDTH = 64;
    localparam int BUS_WIDTH  = 32;
    localparam int STRB_WIDTH = BUS_WIDTH / 8;
    localparam int ADDR_WIDTH = 5;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // byte offsets of the host-visible registers.
    localparam logic [ADDR_WIDTH-1:0] REG_A_LO   = 5'h00;
    localparam logic [ADDR_WIDTH-1:0] REG_A_HI   = 5'h04;
    localparam logic [ADDR_WIDTH-1:0] REG_B_LO   = 5'h08;
    localparam logic [ADDR_WIDTH-1:0] REG_B_HI   = 5'h0C;
    localparam logic [ADDR_WIDTH-1:0] REG_OP     = 5'h10;
    localparam logic [ADDR_WIDTH-1:0] REG_RES_LO = 5'h14;
    localparam logic [ADDR_WIDTH-1:0] REG_RES_HI = 5'h18;
    localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 5'h1C;

    localparam int STATUS_DONE_BIT = 0;
    localparam int STATUS_ZERO_BIT = 1;

    // bit 4 marks the 32-bit word forms.
    typedef enum logic [4:0] {
        OP_ADD   = 5'b00000,
        OP_SLL   = 5'b00001,
        OP_SLT   = 5'b00010,
        OP_SLTU  = 5'b00011,
        OP_XOR   = 5'b00100,
        OP_SRL   = 5'b00101,
        OP_OR    = 5'b00110,
        OP_AND   = 5'b00111,
        OP_SUB   = 5'b01000,
        OP_SRA   = 5'b01101,
        OP_PASSB = 5'b01111,
        OP_ADDW  = 5'b10000,
        OP_SLLW  = 5'b10001,
        OP_SRLW  = 5'b10101,
        OP_SUBW  = 5'b11000,
        OP_SRAW  = 5'b11101
    } aluOpE;

    typedef enum logic [2:0] {
        SEL_ADDER = 3'd0,
        SEL_AND   = 3'd1,
        SEL_OR    = 3'd2,
        SEL_XOR   = 3'd3,
        SEL_SHIFT = 3'd4,
        SEL_PASSB = 3'd5,
        SEL_CMP   = 3'd6
    } resultSelE;

endpackage

`default_nettype wire

//--- src/aluRegs.sv
// AXI4-Lite register block for the ALU
`timescale 1ns/1ps
`default_nettype none

module aluRegs import aluPkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [BUS_WIDTH-1:0]  wdata,
    input  logic [STRB_WIDTH-1:0] wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [ADDR_WIDTH-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [BUS_WIDTH-1:0]  rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [DATA_WIDTH-1:0] operandA,
    output logic [DATA_WIDTH-1:0] operandB,
    output aluOpE                 aluOp,
    input  logic [DATA_WIDTH-1:0] result,
    input  logic                  zero
);

    logic                  start;       // opcode written last cycle.
    logic                  writeAck;
    logic                  readPend;
    logic [ADDR_WIDTH-1:0] readAddr;
    logic [BUS_WIDTH-1:0]  readMux;
    logic [DATA_WIDTH-1:0] latchedResult;
    logic                  latchedZero;
    logic                  done;

    function automatic logic [BUS_WIDTH-1:0] mergeBytes(input logic [BUS_WIDTH-1:0] old,
                                                       input logic [BUS_WIDTH-1:0] data,
                                                       input logic [STRB_WIDTH-1:0] strb);
        logic [BUS_WIDTH-1:0] merged;
        merged = old;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = data[8*i +: 8];
            end
        end
        return merged;
    endfunction

    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

    always_ff @(posedge clock) begin
        if (reset) begin
            awready       <= 1'b0;
            wready        <= 1'b0;
            bvalid        <= 1'b0;
            writeAck      <= 1'b0;
            start         <= 1'b0;
            operandA      <= '0;
            operandB      <= '0;
            aluOp         <= OP_ADD;
            latchedResult <= '0;
            latchedZero   <= 1'b0;
            done          <= 1'b0;
        end else begin
            start <= 1'b0;
            if (awready && awvalid && wvalid) begin
                awready  <= 1'b0;
                wready   <= 1'b0;
                writeAck <= 1'b1;
                case (awaddr)
                    REG_A_LO: operandA[31:0] <= mergeBytes(operandA[31:0], wdata, wstrb);
                    REG_A_HI: operandA[63:32] <= mergeBytes(operandA[63:32], wdata, wstrb);
                    REG_B_LO: operandB[31:0] <= mergeBytes(operandB[31:0], wdata, wstrb);
                    REG_B_HI: operandB[63:32] <= mergeBytes(operandB[63:32], wdata, wstrb);
                    REG_OP: begin
                        if (wstrb[0]) begin
                            aluOp <= aluOpE'(wdata[4:0]);
                        end
                        start <= 1'b1;
                    end
                    default: ;  // read-only or unmapped.
                endcase
                if (awaddr inside {REG_A_LO, REG_A_HI, REG_B_LO, REG_B_HI, REG_OP}) begin
                    done <= 1'b0;
                end
            end else if (!bvalid && !writeAck && awvalid && wvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end

            // ALU has settled on the new opcode by now.
            if (start) begin
                latchedResult <= result;
                latchedZero   <= zero;
                done          <= 1'b1;
            end

            if (writeAck) begin
                writeAck <= 1'b0;
                bvalid   <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        readMux = '0;
        case (readAddr)
            REG_A_LO:   readMux = operandA[31:0];
            REG_A_HI:   readMux = operandA[63:32];
            REG_B_LO:   readMux = operandB[31:0];
            REG_B_HI:   readMux = operandB[63:32];
            REG_OP:     readMux[4:0] = aluOp;
            REG_RES_LO: readMux = latchedResult[31:0];
            REG_RES_HI: readMux = latchedResult[63:32];
            REG_STATUS: begin
                readMux[STATUS_DONE_BIT] = done;
                readMux[STATUS_ZERO_BIT] = latchedZero;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            arready  <= 1'b0;
            readPend <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
        end else begin
            if (arvalid && arready) begin
                arready  <= 1'b0;
                readPend <= 1'b1;
            end else if (!arready && !readPend && !rvalid) begin
                arready <= 1'b1;
            end
            if (readPend) begin
                readPend <= 1'b0;
                rvalid   <= 1'b1;
                rdata    <= readMux;    // held until rready.
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            readAddr <= araddr;
        end
    end

endmodule

`default_nettype wire

//--- src/aluTop.sv
// ALU coprocessor top level
`timescale 1ns/1ps
`default_nettype none

module aluTop import aluPkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [ADDR_WIDTH-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [BUS_WIDTH-1:0]  wdata,
    input  logic [STRB_WIDTH-1:0] wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [ADDR_WIDTH-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [BUS_WIDTH-1:0]  rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready
);

    logic [DATA_WIDTH-1:0] operandA;
    logic [DATA_WIDTH-1:0] operandB;
    logic [DATA_WIDTH-1:0] result;
    logic                  zero;
    aluOpE                 aluOp;

    aluRegs regs (
        .clock   (clock),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .operandA(operandA),
        .operandB(operandB),
        .aluOp   (aluOp),
        .result  (result),
        .zero    (zero)
    );

    alu core (
        .operandA(operandA),
        .operandB(operandB),
        .aluOp   (aluOp),
        .result  (result),
        .zero    (zero)
    );

endmodule

`default_nettype wire

//--- tb/tbAluTop.sv
// ALU coprocessor testbench
`timescale 1ns/1ps
`default_nettype none

module tbAluTop import aluPkg::*; ();

    localparam int WAIT_LIMIT = 64;
    localparam logic [4:0] OP_LIST [20] = '{
        OP_ADD, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_OR, OP_AND,
        OP_SUB, OP_SRA, OP_PASSB, OP_ADDW, OP_SLLW, OP_SRLW, OP_SUBW, OP_SRAW,
        5'b01001, 5'b01010, 5'b10010, 5'b11111  // undefined, these act as add.
    };

    logic                  clock;
    logic                  reset;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [BUS_WIDTH-1:0]  wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [ADDR_WIDTH-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [BUS_WIDTH-1:0]  rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    logic [63:0] rngState = 64'd19;
    logic [31:0] modelWord [4];     // A_LO, A_HI, B_LO, B_HI.
    logic        stallEnable;
    logic        hung;
    int          errorCount;
    int          testsRun;
    int          testsFailed;

    aluTop dut (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [63:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 7);
        rngState = rngState ^ (rngState << 17);
        return rngState;
    endfunction

    function automatic logic pickReady();
        logic [63:0] r;
        r = nextRandom();
        return stallEnable ? (r[1:0] != 2'b00) : 1'b1;
    endfunction

    function automatic logic [63:0] signExtendWord(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // returns {zero, result}.
    function automatic logic [64:0] modelAlu(input logic [4:0] op, input logic [63:0] a,
                                             input logic [63:0] b);
        logic [63:0] res;
        logic [63:0] sum;
        logic [63:0] diff;
        logic [31:0] word;
        logic        useDiff;
        sum = a + b;
        diff = a - b;
        word = '0;
        useDiff = op inside {OP_SUB, OP_SUBW, OP_SLT, OP_SLTU};
        case (op)
            OP_SUB:   res = diff;
            OP_ADDW:  res = signExtendWord(sum[31:0]);
            OP_SUBW:  res = signExtendWord(diff[31:0]);
            OP_SLL:   res = a << b[5:0];
            OP_SRL:   res = a >> b[5:0];
            OP_SRA:   res = $signed(a) >>> b[5:0];
            OP_SLLW: begin
                word = a[31:0] << b[4:0];
                res = signExtendWord(word);
            end
            OP_SRLW: begin
                word = a[31:0] >> b[4:0];
                res = signExtendWord(word);
            end
            OP_SRAW: begin
                word = $signed(a[31:0]) >>> b[4:0];
                res = signExtendWord(word);
            end
            OP_SLT:   res = {63'b0, ($signed(a) < $signed(b))};
            OP_SLTU:  res = {63'b0, (a < b)};
            OP_XOR:   res = a ^ b;
            OP_OR:    res = a | b;
            OP_AND:   res = a & b;
            OP_PASSB: res = b;
            default:  res = sum;
        endcase
        return {(useDiff ? (diff == '0) : (sum == '0)), res};
    endfunction

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (!hung && expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic channelTimeout(input string channel);
        $display("timeout: the %s channel never completed its handshake", channel);
        hung = 1'b1;
    endtask

    task automatic busWrite(input logic [4:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        int   waitCount;
        logic held;
        if (hung) return;
        @(negedge clock);
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        awvalid = 1'b1;
        wvalid = 1'b1;
        waitCount = 0;
        while (!(awready && wready)) begin
            if (waitCount == WAIT_LIMIT) begin
                channelTimeout("write address and data");
                return;
            end
            @(negedge clock);
            waitCount++;
        end
        @(negedge clock);
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = pickReady();
        held = 1'b0;
        waitCount = 0;
        while (!(bvalid && bready)) begin
            if (held && !bvalid) begin
                $display("bus error: write response dropped before it was accepted");
                errorCount++;
            end
            held = bvalid;
            if (waitCount == WAIT_LIMIT) begin
                channelTimeout("write response");
                return;
            end
            @(negedge clock);
            bready = pickReady();
            waitCount++;
        end
        checkValue("write response code", 64'd0, {62'b0, bresp});
        @(negedge clock);
        bready = 1'b0;
    endtask

    task automatic busRead(input logic [4:0] addr, output logic [31:0] data);
        int          waitCount;
        logic        held;
        logic [31:0] heldData;
        data = '0;
        if (hung) return;
        @(negedge clock);
        araddr = addr;
        arvalid = 1'b1;
        waitCount = 0;
        while (!arready) begin
            if (waitCount == WAIT_LIMIT) begin
                channelTimeout("read address");
                return;
            end
            @(negedge clock);
            waitCount++;
        end
        @(negedge clock);
        arvalid = 1'b0;
        rready = pickReady();
        held = 1'b0;
        heldData = '0;
        waitCount = 0;
        while (!(rvalid && rready)) begin
            if (held && (!rvalid || rdata !== heldData)) begin
                $display("bus error: read data changed or dropped before it was accepted");
                errorCount++;
            end
            held = rvalid;
            heldData = rdata;
            if (waitCount == WAIT_LIMIT) begin
                channelTimeout("read data");
                return;
            end
            @(negedge clock);
            rready = pickReady();
            waitCount++;
        end
        if (held && rdata !== heldData) begin
            $display("bus error: read data changed while waiting for rready");
            errorCount++;
        end
        checkValue("read response code", 64'd0, {62'b0, rresp});
        data = rdata;
        @(negedge clock);
        rready = 1'b0;
    endtask

    task automatic writeWord(input int k, input logic [31:0] value);
        modelWord[k] = value;
        busWrite(5'(k * 4), value, 4'hF);
    endtask

    task automatic writeOperands(input logic [63:0] a, input logic [63:0] b);
        writeWord(0, a[31:0]);
        writeWord(1, a[63:32]);
        writeWord(2, b[31:0]);
        writeWord(3, b[63:32]);
    endtask

    task automatic checkComputation(input string name, input logic [4:0] op);
        logic [64:0] expected;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] status;
        expected = modelAlu(op, {modelWord[1], modelWord[0]}, {modelWord[3], modelWord[2]});
        busWrite(REG_OP, {27'b0, op}, 4'hF);
        busRead(REG_RES_LO, lo);
        busRead(REG_RES_HI, hi);
        busRead(REG_STATUS, status);
        checkValue({name, " result"}, expected[63:0], {hi, lo});
        checkValue({name, " zero"}, {63'b0, expected[64]}, {63'b0, status[STATUS_ZERO_BIT]});
        checkValue({name, " done"}, 64'd1, {63'b0, status[STATUS_DONE_BIT]});
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testsRun++;
        if (errorCount == errorsBefore && !hung) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        logic [63:0] r;
        logic [63:0] a;
        logic [31:0] data;
        logic [31:0] mask;
        logic [3:0]  strb;
        logic [64:0] expected;
        int          errorsBefore;
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        stallEnable = 1'b0;
        hung = 1'b0;
        errorCount = 0;
        testsRun = 0;
        testsFailed = 0;
        for (int k = 0; k < 4; k++) begin
            modelWord[k] = '0;
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        errorsBefore = errorCount;
        for (int k = 0; k < 8; k++) begin
            busRead(5'(k * 4), data);
            checkValue($sformatf("reset offset %02h", k * 4), 64'd0, {32'b0, data});
        end
        reportTest("reset values", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < 200; i++) begin
            writeOperands(nextRandom(), nextRandom());
            checkComputation($sformatf("random %0d op %b", i, OP_LIST[i % 20]), OP_LIST[i % 20]);
        end
        reportTest("random operations", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < 10; i++) begin
            a = nextRandom();
            writeOperands(a, a);
            checkComputation($sformatf("equal %0d sub", i), OP_SUB);
            checkComputation($sformatf("equal %0d sltu", i), OP_SLTU);
            checkComputation($sformatf("equal %0d subw", i), OP_SUBW);
            writeOperands(a, -a);   // a + b wraps to zero.
            checkComputation($sformatf("negated %0d add", i), OP_ADD);
        end
        reportTest("zero flag", errorsBefore);

        errorsBefore = errorCount;
        writeOperands(nextRandom(), nextRandom());
        checkComputation("done after opcode", OP_XOR);
        r = nextRandom();
        writeWord(0, r[31:0]);
        busRead(REG_STATUS, data);
        checkValue("done after operand write", 64'd0, {63'b0, data[STATUS_DONE_BIT]});
        checkComputation("done after second opcode", OP_OR);
        reportTest("done bit", errorsBefore);

        errorsBefore = errorCount;
        for (int k = 0; k < 4; k++) begin
            r = nextRandom();
            writeWord(k, r[31:0]);
            r = nextRandom();
            strb = r[35:32];
            mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
            modelWord[k] = (modelWord[k] & ~mask) | (r[31:0] & mask);
            busWrite(5'(k * 4), r[31:0], strb);
            busRead(5'(k * 4), data);
            checkValue($sformatf("strobe offset %02h", k * 4), {32'b0, modelWord[k]}, {32'b0, data});
        end
        busWrite(5'h02, 32'hFFFF_FFFF, 4'hF);
        busRead(REG_A_LO, data);
        checkValue("unmapped write", {32'b0, modelWord[0]}, {32'b0, data});
        checkComputation("strobed operands", OP_ADD);
        expected = modelAlu(OP_ADD, {modelWord[1], modelWord[0]}, {modelWord[3], modelWord[2]});
        busWrite(REG_RES_LO, 32'hDEAD_BEEF, 4'hF);
        busWrite(REG_RES_HI, 32'hCAFE_F00D, 4'hF);
        busWrite(REG_STATUS, 32'h0000_0000, 4'hF);
        busRead(REG_RES_LO, data);
        checkValue("read-only res_lo", {32'b0, expected[31:0]}, {32'b0, data});
        busRead(REG_RES_HI, data);
        checkValue("read-only res_hi", {32'b0, expected[63:32]}, {32'b0, data});
        busRead(REG_STATUS, data);
        checkValue("read-only status", {62'b0, expected[64], 1'b1}, {32'b0, data});
        busRead(5'h01, data);
        checkValue("unmapped read 01", 64'd0, {32'b0, data});
        busRead(5'h0E, data);
        checkValue("unmapped read 0e", 64'd0, {32'b0, data});
        busRead(5'h1F, data);
        checkValue("unmapped read 1f", 64'd0, {32'b0, data});
        reportTest("strobes and read-only", errorsBefore);

        errorsBefore = errorCount;
        stallEnable = 1'b1;     // random bready and rready from here on.
        for (int i = 0; i < 50; i++) begin
            writeOperands(nextRandom(), nextRandom());
            r = nextRandom();
            checkComputation($sformatf("stall %0d", i), OP_LIST[r[4:0] % 20]);
        end
        stallEnable = 1'b0;
        reportTest("back-pressure", errorsBefore);

        $display("tests run %0d, failed %0d, check errors %0d", testsRun, testsFailed,
                 errorCount);
        if (errorCount == 0 && !hung) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
